//--- bp_macros.svh
// Table sizes and data width for the branch predictor, included by every RTL file that sizes a port
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Width of PC and target
`define BP_XLEN 32

// Direct-mapped BTB geometry
`define BP_BTB_ENTRIES 32
// Index bits, taken from PC[6:2] with the current size
`define BP_BTB_IDX_BITS 5

// History length, also the PHT index width
`define BP_GHR_BITS 5

`endif

//--- bp_pkg.sv
// RISC-V opcode constants and jump/branch classification, imported by the BTB and gshare blocks
`default_nettype none

package bp_pkg;

    // Major opcodes of the RV32I control-flow instructions
    parameter logic [6:0] OP_JAL    = 7'b1101111;
    parameter logic [6:0] OP_JALR   = 7'b1100111;
    parameter logic [6:0] OP_BRANCH = 7'b1100011;

    // Unconditional jumps, always predicted taken on a BTB hit
    function automatic logic is_jump(input logic [6:0] op);
        logic result;
        result = (op == OP_JAL) || (op == OP_JALR);
        return result;
    endfunction

    // Conditional branches, direction comes from the PHT
    function automatic logic is_branch(input logic [6:0] op);
        logic result;
        result = (op == OP_BRANCH);
        return result;
    endfunction

endpackage

`default_nettype wire

//--- bp_if.sv
// Interfaces between the predictor blocks: BTB lookup result and resolved updates from execute
`default_nettype none

`include "bp_macros.svh"

// Combinational BTB result for the current fetch PC
interface btb_lookup_if;
    logic                hit;
    logic                kind_jump;
    logic                kind_branch;
    logic [`BP_XLEN-1:0] target;

    modport source (output hit, output kind_jump, output kind_branch, output target);
    modport sink   (input hit, input kind_jump, input kind_branch, input target);
endinterface

// Resolved instruction from execute, consumed on every edge with valid high
interface bp_update_if;
    logic                    valid;
    logic [`BP_XLEN-1:0]     pc;
    logic [6:0]              op;
    logic [`BP_XLEN-1:0]     target;
    logic                    taken;
    // PHT slot used when this instruction was fetched
    logic [`BP_GHR_BITS-1:0] pht_index;

    modport sink (
        input valid, input pc, input op,
        input target, input taken, input pht_index
    );
endinterface

`default_nettype wire

//--- btb.sv
// Direct-mapped branch target buffer tagged with the full PC; allocated from execute updates
`default_nettype none

`include "bp_macros.svh"

module btb
    import bp_pkg::*;
(
    input  logic                clk,
    input  logic                reset_i,
    input  logic [`BP_XLEN-1:0] pc_i,
    bp_update_if.sink           upd,
    btb_lookup_if.source        lookup
);

    // Entry payload
    logic [`BP_XLEN-1:0] target_mem [`BP_BTB_ENTRIES];
    logic [`BP_XLEN-1:0] tag_mem    [`BP_BTB_ENTRIES];
    logic                jump_mem   [`BP_BTB_ENTRIES];
    logic                branch_mem [`BP_BTB_ENTRIES];

    // Per-entry valid bits
    logic [`BP_BTB_ENTRIES-1:0] valid_q;

    logic [`BP_BTB_IDX_BITS-1:0] rd_idx;
    logic [`BP_BTB_IDX_BITS-1:0] wr_idx;
    logic                        upd_jump;
    logic                        upd_branch;
    logic                        alloc;
    logic                        hit;

    // Index from the bits just above the byte offset
    assign rd_idx = pc_i[`BP_BTB_IDX_BITS+1:2];
    assign wr_idx = upd.pc[`BP_BTB_IDX_BITS+1:2];

    assign upd_jump   = is_jump(upd.op);
    assign upd_branch = is_branch(upd.op);

    // Only control-flow instructions claim an entry
    assign alloc = upd.valid && (upd_jump || upd_branch);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Replaces whatever occupied this index before
    always_ff @(posedge clk) begin
        if (alloc) begin
            target_mem[wr_idx] <= upd.target;
            tag_mem[wr_idx]    <= upd.pc;
            jump_mem[wr_idx]   <= upd_jump;
            branch_mem[wr_idx] <= upd_branch;
        end
    end

    // Full-PC tag compare, so aliases at PC+128 miss
    assign hit = valid_q[rd_idx] && (tag_mem[rd_idx] == pc_i);

    always_comb begin
        lookup.hit         = hit;
        lookup.kind_jump   = 1'b0;
        lookup.kind_branch = 1'b0;
        lookup.target      = '0;
        if (hit) begin
            lookup.kind_jump   = jump_mem[rd_idx];
            lookup.kind_branch = branch_mem[rd_idx];
            lookup.target      = target_mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- direction_predictor.sv
// Gshare direction predictor: GHR, two-bit PHT counters and the final taken/target choice
`default_nettype none

`include "bp_macros.svh"

module direction_predictor
    import bp_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`BP_XLEN-1:0]     pc_i,
    input  logic                    ghr_reset_i,
    bp_update_if.sink               upd,
    btb_lookup_if.sink              lookup,
    output logic                    taken_o,
    output logic [`BP_XLEN-1:0]     target_o,
    output logic [`BP_GHR_BITS-1:0] pht_index_o
);

    localparam int PHT_ENTRIES = 1 << `BP_GHR_BITS;

    // Two-bit saturating counters, MSB is the prediction
    logic [1:0]              pht_q [PHT_ENTRIES];
    logic [`BP_GHR_BITS-1:0] ghr_q;

    logic [`BP_GHR_BITS-1:0] rd_idx;
    logic [1:0]              upd_ctr;
    logic                    branch_upd;

    assign branch_upd = upd.valid && is_branch(upd.op);
    assign upd_ctr    = pht_q[upd.pht_index];

    // Gshare hash of PC bits and history
    assign rd_idx      = pc_i[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign pht_index_o = rd_idx;

    // Counters start weakly not taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (branch_upd) begin
            if (upd.taken && (upd_ctr != 2'b11)) begin
                pht_q[upd.pht_index] <= upd_ctr + 2'd1;
            end else if (!upd.taken && (upd_ctr != 2'b00)) begin
                pht_q[upd.pht_index] <= upd_ctr - 2'd1;
            end
        end
    end

    // Newest outcome enters at the MSB; recovery clear wins over a shift
    always_ff @(posedge clk) begin
        if (reset_i || ghr_reset_i) begin
            ghr_q <= '0;
        end else if (branch_upd) begin
            ghr_q <= {upd.taken, ghr_q[`BP_GHR_BITS-1:1]};
        end
    end

    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        if (lookup.hit) begin
            if (lookup.kind_jump) begin
                taken_o  = 1'b1;
                target_o = lookup.target;
            end else if (lookup.kind_branch) begin
                taken_o  = pht_q[rd_idx][1];
                target_o = lookup.target;
            end
        end
    end

endmodule

`default_nettype wire

//--- branch_predictor.sv
// Fetch-stage branch predictor top: plain ports for fetch and execute, BTB plus gshare inside
`default_nettype none

`include "bp_macros.svh"

module branch_predictor (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`BP_XLEN-1:0]     pc_i,
    input  logic                    ghr_reset_i,
    input  logic                    upd_valid_i,
    input  logic [`BP_XLEN-1:0]     upd_pc_i,
    input  logic [6:0]              upd_op_i,
    input  logic [`BP_XLEN-1:0]     upd_target_i,
    input  logic                    upd_taken_i,
    input  logic [`BP_GHR_BITS-1:0] upd_pht_index_i,
    output logic                    taken_o,
    output logic [`BP_XLEN-1:0]     target_o,
    output logic [`BP_GHR_BITS-1:0] pht_index_o
);

    btb_lookup_if lookup_bus ();
    bp_update_if  upd_bus ();

    // Resolved instruction from execute, one per cycle at most
    assign upd_bus.valid     = upd_valid_i;
    assign upd_bus.pc        = upd_pc_i;
    assign upd_bus.op        = upd_op_i;
    assign upd_bus.target    = upd_target_i;
    assign upd_bus.taken     = upd_taken_i;
    assign upd_bus.pht_index = upd_pht_index_i;

    btb u_btb (
        .clk     (clk),
        .reset_i (reset_i),
        .pc_i    (pc_i),
        .upd     (upd_bus.sink),
        .lookup  (lookup_bus.source)
    );

    direction_predictor u_dir (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .ghr_reset_i (ghr_reset_i),
        .upd         (upd_bus.sink),
        .lookup      (lookup_bus.sink),
        .taken_o     (taken_o),
        .target_o    (target_o),
        .pht_index_o (pht_index_o)
    );

endmodule

`default_nettype wire

//--- tb_bp_vectors.svh
// Step table for the branch predictor testbench, included inside the testbench module
`ifndef TB_BP_VECTORS_SVH
`define TB_BP_VECTORS_SVH

// Row columns: name, lookup pc, ghr reset, expected taken, expected target, expected pht index
// A set_update call attaches an update to the next row; expected values reflect earlier rows only
task automatic build_table();
    logic [`BP_XLEN-1:0] ta;
    logic [`BP_XLEN-1:0] ta2;
    logic [`BP_XLEN-1:0] tbr;
    logic [`BP_XLEN-1:0] tc;
    logic [`BP_XLEN-1:0] tx;
    logic [`BP_XLEN-1:0] rpc;
    ta  = $urandom | 32'h0000_1000;
    ta2 = $urandom | 32'h0000_1000;
    tbr = $urandom | 32'h0000_1000;
    tc  = $urandom | 32'h0000_1000;
    tx  = $urandom | 32'h0000_1000;
    rpc = $urandom & 32'hFFFF_FFFC;

    // Empty BTB, index is just the fetch PC bits
    add_step("reset_a", PC_A, 0, 0, 0, 5'd4);
    add_step("reset_c", PC_C, 0, 0, 0, 5'd18);
    add_step("reset_rand", rpc, 0, 0, 0, rpc[6:2]);

    // Jump allocation, alias at A+128 and eviction
    set_update(1, PC_A, OP_JAL, ta, 1, 5'd4);
    add_step("jal_alloc_a", PC_A, 0, 0, 0, 5'd4);
    add_step("jal_hit_a", PC_A, 0, 1, ta, 5'd4);
    add_step("alias_miss", PC_A2, 0, 0, 0, 5'd4);
    set_update(1, PC_A2, OP_JALR, ta2, 1, 5'd4);
    add_step("alias_alloc", PC_A, 0, 1, ta, 5'd4);
    add_step("evicted_a", PC_A, 0, 0, 0, 5'd4);
    add_step("alias_hit", PC_A2, 0, 1, ta2, 5'd4);

    // Saturating counter at PHT slot 9, history held at zero
    set_update(1, PC_B, OP_BRANCH, tbr, 1, 5'd9);
    add_step("br_alloc", PC_B, 1, 0, 0, 5'd9);
    set_update(1, PC_B, OP_BRANCH, tbr, 1, 5'd9);
    add_step("br_taken_1", PC_B, 1, 1, tbr, 5'd9);
    set_update(1, PC_B, OP_BRANCH, tbr, 1, 5'd9);
    add_step("br_taken_2", PC_B, 1, 1, tbr, 5'd9);
    add_step("br_saturated", PC_B, 1, 1, tbr, 5'd9);
    set_update(1, PC_B, OP_BRANCH, tbr, 0, 5'd9);
    add_step("br_nt_1", PC_B, 1, 1, tbr, 5'd9);
    add_step("br_still_taken", PC_B, 1, 1, tbr, 5'd9);
    set_update(1, PC_B, OP_BRANCH, tbr, 0, 5'd9);
    add_step("br_nt_2", PC_B, 1, 1, tbr, 5'd9);
    set_update(1, PC_B, OP_BRANCH, tbr, 0, 5'd9);
    add_step("br_nt_3", PC_B, 1, 0, tbr, 5'd9);
    add_step("br_pred_nt", PC_B, 1, 0, tbr, 5'd9);
    set_update(1, PC_B, OP_BRANCH, tbr, 0, 5'd9);
    add_step("br_floor", PC_B, 1, 0, tbr, 5'd9);
    set_update(1, PC_B, OP_BRANCH, tbr, 1, 5'd9);
    add_step("br_one_taken", PC_B, 1, 0, tbr, 5'd9);
    add_step("br_weak_nt", PC_B, 1, 0, tbr, 5'd9);

    // Outcomes 1 then 0 leave the history at 01000
    set_update(1, PC_C, OP_BRANCH, tc, 1, 5'd18);
    add_step("hist_shift_1", PC_D, 0, 0, 0, 5'd0);
    set_update(1, PC_C, OP_BRANCH, tc, 0, 5'd18);
    add_step("hist_shift_0", PC_D, 0, 0, 0, 5'd16);
    add_step("hist_index_d", PC_D, 0, 0, 0, 5'd8);
    add_step("hist_index_jump", PC_A2, 0, 1, ta2, 5'd12);
    add_step("hist_clear", PC_D, 1, 0, 0, 5'd8);
    add_step("hist_cleared_d", PC_D, 0, 0, 0, 5'd0);
    add_step("hist_cleared_c", PC_C, 0, 0, tc, 5'd18);

    // ALU opcodes and idle updates touch neither BTB nor history
    set_update(1, PC_C, OP_BRANCH, tc, 1, 5'd18);
    add_step("alu_prep", PC_C, 0, 0, tc, 5'd18);
    add_step("alu_before", PC_C, 0, 0, tc, 5'd2);
    set_update(1, PC_C, OP_ALU_REG, tx, 1, 5'd2);
    add_step("alu_reg_upd", PC_C, 0, 0, tc, 5'd2);
    add_step("alu_reg_after", PC_C, 0, 0, tc, 5'd2);
    add_step("alu_jump_before", PC_A2, 0, 1, ta2, 5'd20);
    set_update(1, PC_A2, OP_ALU_IMM, tx, 1, 5'd20);
    add_step("alu_imm_upd", PC_A2, 0, 1, ta2, 5'd20);
    add_step("alu_imm_after", PC_A2, 0, 1, ta2, 5'd20);
    set_update(0, PC_C, OP_BRANCH, tx, 1, 5'd2);
    add_step("idle_branch", PC_C, 0, 0, tc, 5'd2);
    add_step("idle_after", PC_C, 0, 0, tc, 5'd2);
endtask

`endif

//--- tb_branch_predictor.sv
// Testbench that applies the step table to the branch predictor top and checks every lookup
`default_nettype none

`include "bp_macros.svh"

module tb_branch_predictor
    import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int MARGIN_CYCLES = 20;

    // A and A+128 share BTB index 4
    localparam logic [`BP_XLEN-1:0] PC_A  = 32'h0000_1010;
    localparam logic [`BP_XLEN-1:0] PC_A2 = 32'h0000_1090;
    localparam logic [`BP_XLEN-1:0] PC_B  = 32'h0000_2024;
    localparam logic [`BP_XLEN-1:0] PC_C  = 32'h0000_3048;
    localparam logic [`BP_XLEN-1:0] PC_D  = 32'h0000_4000;

    localparam logic [6:0] OP_ALU_REG = 7'b0110011;
    localparam logic [6:0] OP_ALU_IMM = 7'b0010011;

    logic                    clk;
    logic                    reset_i;
    logic [`BP_XLEN-1:0]     pc_i;
    logic                    ghr_reset_i;
    logic                    upd_valid_i;
    logic [`BP_XLEN-1:0]     upd_pc_i;
    logic [6:0]              upd_op_i;
    logic [`BP_XLEN-1:0]     upd_target_i;
    logic                    upd_taken_i;
    logic [`BP_GHR_BITS-1:0] upd_pht_index_i;
    logic                    taken_o;
    logic [`BP_XLEN-1:0]     target_o;
    logic [`BP_GHR_BITS-1:0] pht_index_o;

    // Step table columns
    string                   step_name [$];
    logic [`BP_XLEN-1:0]     step_pc [$];
    logic                    step_ghr_rst [$];
    logic                    step_valid [$];
    logic [`BP_XLEN-1:0]     step_upd_pc [$];
    logic [6:0]              step_op [$];
    logic [`BP_XLEN-1:0]     step_target [$];
    logic                    step_taken [$];
    logic [`BP_GHR_BITS-1:0] step_upd_idx [$];
    logic                    exp_taken [$];
    logic [`BP_XLEN-1:0]     exp_target [$];
    logic [`BP_GHR_BITS-1:0] exp_idx [$];

    // Update waiting for the next row
    logic                    pend_valid = 1'b0;
    logic [`BP_XLEN-1:0]     pend_pc = '0;
    logic [6:0]              pend_op = '0;
    logic [`BP_XLEN-1:0]     pend_target = '0;
    logic                    pend_taken = 1'b0;
    logic [`BP_GHR_BITS-1:0] pend_idx = '0;

    bit table_ready = 1'b0;
    int checks_ok = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    branch_predictor DUT (
        .clk             (clk),
        .reset_i         (reset_i),
        .pc_i            (pc_i),
        .ghr_reset_i     (ghr_reset_i),
        .upd_valid_i     (upd_valid_i),
        .upd_pc_i        (upd_pc_i),
        .upd_op_i        (upd_op_i),
        .upd_target_i    (upd_target_i),
        .upd_taken_i     (upd_taken_i),
        .upd_pht_index_i (upd_pht_index_i),
        .taken_o         (taken_o),
        .target_o        (target_o),
        .pht_index_o     (pht_index_o)
    );

    task automatic set_update(input logic v, input logic [`BP_XLEN-1:0] pc,
                              input logic [6:0] op, input logic [`BP_XLEN-1:0] tgt,
                              input logic tk, input logic [`BP_GHR_BITS-1:0] idx);
        pend_valid  = v;
        pend_pc     = pc;
        pend_op     = op;
        pend_target = tgt;
        pend_taken  = tk;
        pend_idx    = idx;
    endtask

    task automatic add_step(input string name, input logic [`BP_XLEN-1:0] pc,
                            input logic ghr_rst, input logic e_taken,
                            input logic [`BP_XLEN-1:0] e_target,
                            input logic [`BP_GHR_BITS-1:0] e_idx);
        step_name.push_back(name);
        step_pc.push_back(pc);
        step_ghr_rst.push_back(ghr_rst);
        step_valid.push_back(pend_valid);
        step_upd_pc.push_back(pend_pc);
        step_op.push_back(pend_op);
        step_target.push_back(pend_target);
        step_taken.push_back(pend_taken);
        step_upd_idx.push_back(pend_idx);
        exp_taken.push_back(e_taken);
        exp_target.push_back(e_target);
        exp_idx.push_back(e_idx);
        set_update(1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    `include "tb_bp_vectors.svh"

    task automatic check_step(input int i);
        bit failed;
        failed = 1'b0;
        assert (taken_o === exp_taken[i]) checks_ok = checks_ok + 1;
        else begin
            $display("[FAIL] %s taken_o: expected %0b, actual %0b",
                     step_name[i], exp_taken[i], taken_o);
            failed = 1'b1;
        end
        assert (target_o === exp_target[i]) checks_ok = checks_ok + 1;
        else begin
            $display("[FAIL] %s target_o: expected %h, actual %h",
                     step_name[i], exp_target[i], target_o);
            failed = 1'b1;
        end
        assert (pht_index_o === exp_idx[i]) checks_ok = checks_ok + 1;
        else begin
            $display("[FAIL] %s pht_index_o: expected %b, actual %b",
                     step_name[i], exp_idx[i], pht_index_o);
            failed = 1'b1;
        end
        if (failed) begin
            tests_failed = tests_failed + 1;
        end else begin
            tests_passed = tests_passed + 1;
            $display("[PASS] %s", step_name[i]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        wait (table_ready);
        #((RESET_CYCLES + step_name.size() + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the step table did not complete in the allowed time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        reset_i         = 1'b1;
        pc_i            = '0;
        ghr_reset_i     = 1'b0;
        upd_valid_i     = 1'b0;
        upd_pc_i        = '0;
        upd_op_i        = '0;
        upd_target_i    = '0;
        upd_taken_i     = 1'b0;
        upd_pht_index_i = '0;
        void'($urandom(99460));
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        // Each row's update lands at the edge after the row is checked
        for (int i = 0; i < step_name.size(); i++) begin
            @(posedge clk);
            pc_i            <= step_pc[i];
            ghr_reset_i     <= step_ghr_rst[i];
            upd_valid_i     <= step_valid[i];
            upd_pc_i        <= step_upd_pc[i];
            upd_op_i        <= step_op[i];
            upd_target_i    <= step_target[i];
            upd_taken_i     <= step_taken[i];
            upd_pht_index_i <= step_upd_idx[i];
            @(negedge clk);
            check_step(i);
        end

        $display("Tests: %0d passed, %0d failed, %0d of %0d checks held",
                 tests_passed, tests_failed, checks_ok, 3 * step_name.size());
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- branch_predictor.f
+incdir+.
bp_pkg.sv
bp_if.sv
btb.sv
direction_predictor.sv
branch_predictor.sv
tb_branch_predictor.sv
